//--- common/chdr_macros.svh
`ifndef CHDR_MACROS_SVH
`define CHDR_MACROS_SVH

// body width on the output stream, 32 or 64
`define CHDR_OUT_WIDTH 32

// header item fifo holds 32 entries
`define CHDR_HDR_FIFO_DEPTH_LOG2 5

// body fifo holds 512 words
`define CHDR_BODY_FIFO_DEPTH_LOG2 9

`endif

//--- common/chdr_pkg.sv
package chdr_pkg;

  ////////////////////////////////////////
  // chdr header word
  ////////////////////////////////////////

  // field order follows the wire format, msb first
  typedef struct packed {
    logic [1:0]  pkt_type;
    logic        has_time;
    logic        eob;
    logic [11:0] seq_num;
    // total bytes, header and time word included
    logic [15:0] length;
    logic [31:0] sid;
  } chdr_hdr_t;

  // one input word, seen either as raw bits or as header fields
  typedef union packed {
    logic [63:0] raw;
    chdr_hdr_t   hdr;
  } chdr_word_u;

  ////////////////////////////////////////
  // header item
  ////////////////////////////////////////

  // hi is the header, lo the timestamp or a second copy of the header
  typedef struct packed {
    chdr_word_u  hi;
    logic [63:0] lo;
  } chdr_hdr_item_t;

endpackage

//--- common/chdr_stream_if.sv
`timescale 1ns/1ps

// 64-bit body stream with valid/ready handshake
interface chdr_stream_if;

  logic [63:0] tdata;
  logic        tlast;
  logic        tvalid;
  logic        tready;

  // producer side
  modport src (
    output tdata,
    output tlast,
    output tvalid,
    input  tready
  );

  // consumer side
  modport snk (
    input  tdata,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

//--- hw/chdr_sync_fifo.sv
`timescale 1ns/1ps

module chdr_sync_fifo #(
  parameter int WIDTH      = 64,
  parameter int DEPTH_LOG2 = 4
) (
  input  logic             pkt_clk,
  input  logic             pkt_rst,
  input  logic [WIDTH-1:0] i_wdata,
  input  logic             i_wvalid,
  output logic             o_wready,
  output logic [WIDTH-1:0] o_rdata,
  output logic             o_rvalid,
  input  logic             i_rready
);

  localparam int DEPTH = 1 << DEPTH_LOG2;
  localparam logic [DEPTH_LOG2:0] FULL_COUNT = {1'b1, {DEPTH_LOG2{1'b0}}};

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  wr_en;
  logic                  rd_en;

  assign o_wready = (count != FULL_COUNT);
  assign o_rvalid = (count != '0);
  assign o_rdata  = mem[rd_ptr];

  assign wr_en = i_wvalid && o_wready;
  assign rd_en = i_rready && o_rvalid;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge pkt_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_wdata;
    end
  end

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge pkt_clk) begin
    if (pkt_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap naturally at the power-of-two depth
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  a_no_overflow: assert property (
    @(posedge pkt_clk) disable iff (pkt_rst)
    count <= FULL_COUNT
  );

  // an empty fifo may only stay empty or gain one entry
  a_no_underflow: assert property (
    @(posedge pkt_clk) disable iff (pkt_rst)
    (count == '0) |=> (count <= 1)
  );

endmodule

//--- deframer/chdr_hdr_splitter.sv
`timescale 1ns/1ps

module chdr_hdr_splitter (
  input  logic                     pkt_clk,
  input  logic                     pkt_rst,
  input  chdr_pkg::chdr_word_u     i_tdata,
  input  logic                     i_tlast,
  input  logic                     i_tvalid,
  output logic                     o_tready,
  output chdr_pkg::chdr_hdr_item_t o_hdr_item,
  output logic                     o_hdr_valid,
  input  logic                     i_hdr_ready,
  chdr_stream_if.src               body
);
  import chdr_pkg::*;

  typedef enum logic [1:0] {
    ST_HEAD = 2'd0,
    ST_TIME = 2'd1,
    ST_BODY = 2'd2
  } state_t;

  state_t     state;
  chdr_word_u held_hdr;
  logic       head_accept;
  logic       time_accept;
  logic       last_accept;

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  assign head_accept = (state == ST_HEAD) && i_tvalid && i_hdr_ready;
  assign time_accept = (state == ST_TIME) && i_tvalid && i_hdr_ready;
  assign last_accept = (state == ST_BODY) && i_tvalid && body.tready && i_tlast;

  // body fifo paces the input only while body words flow
  assign o_tready = (state == ST_BODY) ? body.tready : i_hdr_ready;

  // header item goes out on the header word, or on the time word if present
  assign o_hdr_valid = i_tvalid &&
                       ((state == ST_TIME) ||
                        ((state == ST_HEAD) && !i_tdata.hdr.has_time));

  always_comb begin
    o_hdr_item.hi = (state == ST_TIME) ? held_hdr : i_tdata;
    // without a time word this is just the header again
    o_hdr_item.lo = i_tdata.raw;
  end

  assign body.tdata  = i_tdata.raw;
  assign body.tlast  = i_tlast;
  assign body.tvalid = (state == ST_BODY) && i_tvalid;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_ff @(posedge pkt_clk) begin
    if (pkt_rst) begin
      state <= ST_HEAD;
    end else begin
      case (state)
        ST_HEAD: begin
          if (head_accept) begin
            state <= i_tdata.hdr.has_time ? ST_TIME : ST_BODY;
          end
        end
        ST_TIME: begin
          if (time_accept) begin
            state <= ST_BODY;
          end
        end
        ST_BODY: begin
          if (last_accept) begin
            state <= ST_HEAD;
          end
        end
        default: state <= ST_HEAD;
      endcase
    end
  end

  // header kept until its time word arrives
  always_ff @(posedge pkt_clk) begin
    if (head_accept && i_tdata.hdr.has_time) begin
      held_hdr <= i_tdata;
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // every packet must carry at least one body word
  a_no_empty_pkt: assert property (
    @(posedge pkt_clk) disable iff (pkt_rst)
    (head_accept || time_accept) |-> !i_tlast
  );

  a_state_legal: assert property (
    @(posedge pkt_clk) disable iff (pkt_rst)
    state inside {ST_HEAD, ST_TIME, ST_BODY}
  );

endmodule

//--- deframer/chdr_width_gearbox.sv
`timescale 1ns/1ps

module chdr_width_gearbox #(
  parameter int OUT_WIDTH = 32
) (
  input  logic                     pkt_clk,
  input  logic                     pkt_rst,
  input  chdr_pkg::chdr_hdr_item_t i_hdr_item,
  input  logic                     i_hdr_valid,
  output logic                     o_hdr_ready,
  chdr_stream_if.snk               body,
  output logic [OUT_WIDTH-1:0]     o_tdata,
  output logic [127:0]             o_tuser,
  output logic                     o_tlast,
  output logic                     o_tvalid,
  input  logic                     i_tready
);
  import chdr_pkg::*;

  chdr_word_u hdr_word;
  logic       out_xfer;

  assign hdr_word = i_hdr_item.hi;

  // a beat needs both its header item and a body word
  assign o_tvalid = i_hdr_valid && body.tvalid;
  assign out_xfer = o_tvalid && i_tready;

  // header item stays on tuser for every beat of the packet
  assign o_tuser     = i_hdr_item;
  assign o_hdr_ready = out_xfer && o_tlast;

  generate
    if (OUT_WIDTH == 32) begin : gen_out32

      ////////////////////////////////////////
      // 32-bit output, two beats per word
      ////////////////////////////////////////

      logic half_sel;
      logic short_last;

      // 1 to 4 valid bytes in the final word means it ends on the upper half
      assign short_last = (hdr_word.hdr.length[2:0] inside {3'd1, 3'd2, 3'd3, 3'd4});

      // upper half first
      assign o_tdata    = half_sel ? body.tdata[31:0] : body.tdata[63:32];
      assign o_tlast    = body.tlast && (half_sel || short_last);
      assign body.tready = out_xfer && (half_sel || o_tlast);

      always_ff @(posedge pkt_clk) begin
        if (pkt_rst) begin
          half_sel <= 1'b0;
        end else if (out_xfer) begin
          if (o_tlast) begin
            half_sel <= 1'b0;
          end else begin
            half_sel <= ~half_sel;
          end
        end
      end

    end else begin : gen_out64

      ////////////////////////////////////////
      // 64-bit output
      ////////////////////////////////////////

      assign o_tdata     = body.tdata;
      assign o_tlast     = body.tlast;
      assign body.tready = out_xfer;

    end
  endgenerate

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // relies on both fifos holding their read side until popped
  a_stall_stable: assert property (
    @(posedge pkt_clk) disable iff (pkt_rst)
    (o_tvalid && !i_tready) |=>
      (o_tvalid && $stable(o_tdata) && $stable(o_tlast) && $stable(hdr_word.raw))
  );

endmodule

//--- deframer/chdr_deframer.sv
`timescale 1ns/1ps
`include "chdr_macros.svh"

module chdr_deframer (
  input  logic                       pkt_clk,
  input  logic                       pkt_rst,
  input  logic [63:0]                i_tdata,
  input  logic                       i_tlast,
  input  logic                       i_tvalid,
  output logic                       i_tready,
  output logic [`CHDR_OUT_WIDTH-1:0] o_tdata,
  output logic [127:0]               o_tuser,
  output logic                       o_tlast,
  output logic                       o_tvalid,
  input  logic                       o_tready
);
  import chdr_pkg::*;

  chdr_hdr_item_t hdr_in_item;
  logic           hdr_in_valid;
  logic           hdr_in_ready;
  chdr_hdr_item_t hdr_out_item;
  logic           hdr_out_valid;
  logic           hdr_out_ready;

  chdr_stream_if body_in ();
  chdr_stream_if body_out ();

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  chdr_hdr_splitter u_splitter (
    .pkt_clk     (pkt_clk),
    .pkt_rst     (pkt_rst),
    .i_tdata     (i_tdata),
    .i_tlast     (i_tlast),
    .i_tvalid    (i_tvalid),
    .o_tready    (i_tready),
    .o_hdr_item  (hdr_in_item),
    .o_hdr_valid (hdr_in_valid),
    .i_hdr_ready (hdr_in_ready),
    .body        (body_in)
  );

  ////////////////////////////////////////
  // buffering
  ////////////////////////////////////////

  chdr_sync_fifo #(
    .WIDTH      (128),
    .DEPTH_LOG2 (`CHDR_HDR_FIFO_DEPTH_LOG2)
  ) hdr_fifo (
    .pkt_clk  (pkt_clk),
    .pkt_rst  (pkt_rst),
    .i_wdata  (hdr_in_item),
    .i_wvalid (hdr_in_valid),
    .o_wready (hdr_in_ready),
    .o_rdata  (hdr_out_item),
    .o_rvalid (hdr_out_valid),
    .i_rready (hdr_out_ready)
  );

  // tlast rides in the top bit
  chdr_sync_fifo #(
    .WIDTH      (65),
    .DEPTH_LOG2 (`CHDR_BODY_FIFO_DEPTH_LOG2)
  ) body_fifo (
    .pkt_clk  (pkt_clk),
    .pkt_rst  (pkt_rst),
    .i_wdata  ({body_in.tlast, body_in.tdata}),
    .i_wvalid (body_in.tvalid),
    .o_wready (body_in.tready),
    .o_rdata  ({body_out.tlast, body_out.tdata}),
    .o_rvalid (body_out.tvalid),
    .i_rready (body_out.tready)
  );

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  chdr_width_gearbox #(
    .OUT_WIDTH (`CHDR_OUT_WIDTH)
  ) u_gearbox (
    .pkt_clk     (pkt_clk),
    .pkt_rst     (pkt_rst),
    .i_hdr_item  (hdr_out_item),
    .i_hdr_valid (hdr_out_valid),
    .o_hdr_ready (hdr_out_ready),
    .body        (body_out),
    .o_tdata     (o_tdata),
    .o_tuser     (o_tuser),
    .o_tlast     (o_tlast),
    .o_tvalid    (o_tvalid),
    .i_tready    (o_tready)
  );

endmodule

//--- verif/chdr_deframer_tb.sv
`timescale 1ns/1ps
`include "chdr_macros.svh"

module chdr_deframer_tb;
  import chdr_pkg::*;

  localparam int NUM_PKTS       = 200;
  // worst case beats per packet, with slack for gaps and back-pressure
  localparam int TIMEOUT_CYCLES = NUM_PKTS * 36 * 5;

  logic                       pkt_clk;
  logic                       pkt_rst;
  logic [63:0]                i_tdata;
  logic                       i_tlast;
  logic                       i_tvalid;
  logic                       i_tready;
  logic [`CHDR_OUT_WIDTH-1:0] o_tdata;
  logic [127:0]               o_tuser;
  logic                       o_tlast;
  logic                       o_tvalid;
  logic                       o_tready;

  // input words in send order
  logic [63:0]  in_data[$];
  bit           in_last[$];

  // expected output beats
  logic [63:0]  exp_data[$];
  logic [127:0] exp_user[$];
  bit           exp_last[$];

  int           in_idx;
  int           cycle_count;

  chdr_deframer i_dut (
    .pkt_clk  (pkt_clk),
    .pkt_rst  (pkt_rst),
    .i_tdata  (i_tdata),
    .i_tlast  (i_tlast),
    .i_tvalid (i_tvalid),
    .i_tready (i_tready),
    .o_tdata  (o_tdata),
    .o_tuser  (o_tuser),
    .o_tlast  (o_tlast),
    .o_tvalid (o_tvalid),
    .o_tready (o_tready)
  );

  always #4 pkt_clk = ~pkt_clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: actual 0x%0h expected 0x%0h", name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic push_beat(input logic [63:0] data, input logic [127:0] user,
                           input bit last);
    exp_data.push_back(data);
    exp_user.push_back(user);
    exp_last.push_back(last);
  endtask

  // random packet plus its expected output beats
  task automatic build_packet(input int pkt_num);
    chdr_hdr_t    hdr;
    logic [63:0]  hdr_raw;
    logic [63:0]  time_word;
    logic [63:0]  word;
    logic [127:0] user;
    bit           has_time;
    bit           is_last;
    int           n_body;
    int           last_bytes;
    int           len;
    has_time   = 1'($urandom_range(0, 1));
    n_body     = int'($urandom_range(1, 16));
    last_bytes = int'($urandom_range(1, 8));
    len        = 8 + (has_time ? 8 : 0) + 8 * (n_body - 1) + last_bytes;
    hdr.pkt_type = 2'($urandom_range(0, 3));
    hdr.has_time = has_time;
    hdr.eob      = 1'($urandom_range(0, 1));
    hdr.seq_num  = 12'(pkt_num);
    hdr.length   = 16'(len);
    hdr.sid      = $urandom();
    hdr_raw      = hdr;
    time_word    = {$urandom(), $urandom()};
    in_data.push_back(hdr_raw);
    in_last.push_back(1'b0);
    if (has_time) begin
      in_data.push_back(time_word);
      in_last.push_back(1'b0);
    end
    // no time word means the header shows up in both halves
    user = {hdr_raw, has_time ? time_word : hdr_raw};
    for (int w = 0; w < n_body; w++) begin
      word    = {$urandom(), $urandom()};
      is_last = (w == n_body - 1);
      in_data.push_back(word);
      in_last.push_back(is_last);
      if (`CHDR_OUT_WIDTH == 64) begin
        push_beat(word, user, is_last);
      end else if (is_last && last_bytes <= 4) begin
        // short last word ends on its upper half
        push_beat(64'(word[63:32]), user, 1'b1);
      end else begin
        push_beat(64'(word[63:32]), user, 1'b0);
        push_beat(64'(word[31:0]), user, is_last);
      end
    end
  endtask

  // called at a rising edge, sees the values from before the edge
  task automatic check_output_step();
    if (o_tvalid && o_tready) begin
      if (exp_data.size() == 0) begin
        $display("Output beat arrived after all expected beats were seen");
        $display("Simulation failed");
        $fatal(1, "unexpected output beat");
      end
      check_value("o_tdata", 128'(o_tdata), 128'(exp_data[0]));
      check_value("o_tuser", o_tuser, exp_user[0]);
      check_value("o_tlast", 128'(o_tlast), 128'(exp_last[0]));
      void'(exp_data.pop_front());
      void'(exp_user.pop_front());
      void'(exp_last.pop_front());
    end
  endtask

  task automatic drive_input_step();
    if (i_tvalid && i_tready) begin
      in_idx++;
    end
    // hold the word while it waits for ready
    if (!(i_tvalid && !i_tready)) begin
      if (in_idx < in_data.size() && $urandom_range(0, 3) != 0) begin
        i_tdata  <= in_data[in_idx];
        i_tlast  <= in_last[in_idx];
        i_tvalid <= 1'b1;
      end else begin
        i_tvalid <= 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(84));
    pkt_clk       = 1'b0;
    pkt_rst       = 1'b1;
    i_tdata       = '0;
    i_tlast       = 1'b0;
    i_tvalid      = 1'b0;
    o_tready      = 1'b0;
    in_idx        = 0;
    cycle_count   = 0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      build_packet(p);
    end

    repeat (5) @(posedge pkt_clk);
    pkt_rst <= 1'b0;
    @(posedge pkt_clk);
    // idle state out of reset
    check_value("o_tvalid", 128'(o_tvalid), 128'(0));
    check_value("i_tready", 128'(i_tready), 128'(1));

    while (exp_data.size() > 0) begin
      check_output_step();
      drive_input_step();
      // roughly 60% ready
      o_tready <= ($urandom_range(0, 99) < 60);
      @(posedge pkt_clk);
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles with %0d beats still expected",
                 cycle_count, exp_data.size());
        $display("Simulation failed");
        $fatal(1, "run did not complete");
      end
    end

    // nothing more may come out once the model is drained
    i_tvalid <= 1'b0;
    o_tready <= 1'b1;
    repeat (4) begin
      @(posedge pkt_clk);
      check_value("o_tvalid", 128'(o_tvalid), 128'(0));
    end

    if (in_idx == in_data.size()) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Only %0d of %0d input words were accepted", in_idx, in_data.size());
      $display("Simulation failed");
      $fatal(1, "input not fully consumed");
    end
  end

endmodule

//--- compile.f
+incdir+common
common/chdr_pkg.sv
common/chdr_stream_if.sv
hw/chdr_sync_fifo.sv
deframer/chdr_hdr_splitter.sv
deframer/chdr_width_gearbox.sv
deframer/chdr_deframer.sv
verif/chdr_deframer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the deframer testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module chdr_deframer_tb \
  -o chdr_deframer_sim &&
./obj_dir/chdr_deframer_sim | tee /dev/stderr | grep -q "Simulation passed" &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }
